// ==== Bender.yml ====
package:
  name: color_engine

sources:
  - rtl/color_pkg.sv
  - rtl/header_loader.sv
  - rtl/free_color.sv
  - rtl/enqueue_window.sv
  - rtl/vertex_task_fsm.sv
  - rtl/color_engine.sv
  - target: test
    files:
      - bench/l1_mem_model.sv
      - bench/color_engine_tb.sv

// ==== bench/color_engine_cases.txt ====
# H header words 0 to 9, hex. C ttype locale args stall counter bitmap, hex
# then O ttype locale args per expected task in order, W addr data per expected write
H 00000000 00000014 00000000 00000000 00000000 00000100 00000000 00000200 00000000 00000003
C 0 0 0 0 0 0
O 0 0 3
O 1 0 0
O 1 1 0
O 1 2 0
C 0 0 12 0 0 0
O 1 12 0
O 1 13 0
C 2 5 0 0 0 0000000b
W 450 2
C 2 6 0 0 0 00000000
W 460 0
C 2 7 0 0 0 ffffffff
W 470 20
C 3 3 4 0 1 3
W 818 0
W 81c 13
O 2 3 0
C 3 4 1 0 3 2
W 820 2
C 7 8 0 0 0 0
C 0 5 5 1 0 0
O 0 50 8
O 1 5 0
O 1 6 0
O 1 7 0
C 3 9 0 1 1 10
W 848 0
W 84c 11
O 2 9 0
C 2 2 0 1 0 7
W 420 3

// ==== bench/color_engine_tb.sv ====
`timescale 1ns/100ps

module color_engine_tb;

   localparam int MAX_CASES   = 16;
   localparam int CASE_CYCLES = 300;

   logic                clk;
   logic                rstn;
   logic                start;
   logic                task_out_ready;
   logic                done;
   logic                idle;
   logic                task_out_valid;
   color_pkg::task_t    task_in;
   color_pkg::task_t    task_out;
   color_pkg::mem_req_t mem_req;
   color_pkg::mem_rsp_t mem_rsp;

   logic                         stall_en;
   logic [color_pkg::WORD_W-1:0] hdr [color_pkg::HEADER_WORDS];
   int                           n_cases;
   color_pkg::task_t             case_task [MAX_CASES];
   logic [color_pkg::WORD_W-1:0] case_cnt [MAX_CASES];
   logic [color_pkg::WORD_W-1:0] case_bmp [MAX_CASES];
   logic                         case_stall [MAX_CASES];
   int                           exp_tcase [$];
   color_pkg::task_t             exp_task [$];
   int                           exp_wcase [$];
   logic [color_pkg::WORD_W-1:0] exp_waddr [$];
   logic [color_pkg::WORD_W-1:0] exp_wdata [$];
   color_pkg::task_t             got_task [$];
   color_pkg::task_t             out_s;
   logic                         out_v_s;
   logic                         out_r_s;
   logic [5:0]                   reset_levels;
   int                           cycles;
   int                           cycle_limit = 0;
   int                           passed;
   int                           failed;

   color_engine #(.NUM_COLORS(32)) color_engine_inst (
      .clk(clk), .rstn(rstn), .start(start), .task_in(task_in),
      .task_out_ready(task_out_ready), .mem_rsp(mem_rsp), .done(done), .idle(idle),
      .task_out(task_out), .task_out_valid(task_out_valid), .mem_req(mem_req)
   );

   l1_mem_model #(.WORDS(1024)) mem_model_inst (
      .mem_req(mem_req), .mem_rsp(mem_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // falling edge driver, also collects accepted output tasks
   initial begin
      void'($urandom(64));
      forever begin
         @(negedge clk);
         if (out_v_s && out_r_s) got_task.push_back(out_s);
         mem_model_inst.tick(stall_en);
         task_out_ready = stall_en ? ($urandom_range(2) != 0) : 1'b1;
         out_r_s        = task_out_ready;
         out_v_s        = task_out_valid;
         out_s          = task_out;
      end
   end

   initial begin
      cycles = 0;
      wait (cycle_limit > 0);
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the engine never finished its task", cycles);
            $display("TEST FAILED");
            $finish;
         end
      end
   end

   task automatic read_cases();
      int                           fd;
      int                           code;
      logic [7:0]                   tag;
      logic [8*128-1:0]             line;
      logic [color_pkg::WORD_W-1:0] f [6];
      color_pkg::task_t             t;
      fd = $fopen("bench/color_engine_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open bench/color_engine_cases.txt");
         $display("TEST FAILED");
         $finish;
      end else begin
         while ($fscanf(fd, " %c", tag) == 1) begin
            t = '0;
            case (tag)
               "#": code = $fgets(line, fd);
               "H": begin
                  for (int i = 0; i < color_pkg::HEADER_WORDS; i++) begin
                     code = $fscanf(fd, "%h", hdr[i]);
                  end
               end
               "C": begin
                  code = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                  t.ttype                = f[0][3:0];
                  t.locale               = f[1];
                  t.args                 = f[2];
                  case_task[n_cases]  = t;
                  case_stall[n_cases] = f[3][0];
                  case_cnt[n_cases]   = f[4];
                  case_bmp[n_cases]   = f[5];
                  n_cases++;
               end
               "O": begin
                  code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                  t.ttype  = f[0][3:0];
                  t.locale = f[1];
                  t.args   = f[2];
                  exp_task.push_back(t);
                  exp_tcase.push_back(n_cases - 1);
               end
               "W": begin
                  code = $fscanf(fd, "%h %h", f[0], f[1]);
                  exp_waddr.push_back(f[0]);
                  exp_wdata.push_back(f[1]);
                  exp_wcase.push_back(n_cases - 1);
               end
               default: begin
                  $display("case file holds a line of unknown kind");
                  failed++;
               end
            endcase
         end
         $fclose(fd);
      end
   endtask

   task automatic run_case(input int n);
      int                           errs;
      int                           exp_reads;
      color_pkg::task_t             exp;
      color_pkg::task_t             got;
      logic [color_pkg::WORD_W-1:0] slot;
      logic [color_pkg::WORD_W-1:0] a;
      logic [color_pkg::WORD_W-1:0] d;
      errs = 0;
      slot = (hdr[color_pkg::SCRATCH_BASE_WORD] << 2)
             + (case_task[n].locale << color_pkg::SCRATCH_SHIFT);
      @(posedge clk);
      stall_en = case_stall[n];
      @(negedge clk);
      mem_model_inst.poke(slot + color_pkg::COUNTER_OFFSET, case_cnt[n]);
      mem_model_inst.poke(slot + color_pkg::BITMAP_OFFSET, case_bmp[n]);
      mem_model_inst.wr_addr_q.delete();
      mem_model_inst.wr_data_q.delete();
      mem_model_inst.rd_count = 0;
      got_task.delete();
      start   = 1'b1;
      task_in = case_task[n];
      @(negedge clk);
      start = 1'b0;
      while (done !== 1'b1) @(negedge clk);
      @(negedge clk); // last handshake lands in the logs
      // done lasts one cycle, idle is back right after it
      if ({idle, done, task_out_valid} !== 3'b100) begin
         $display("FAIL case %0d {idle,done,task_out_valid} got %h expected %h", n,
                  {idle, done, task_out_valid}, 3'b100);
         errs++;
      end
      while (exp_tcase.size() > 0 && exp_tcase[0] == n) begin
         void'(exp_tcase.pop_front());
         exp = exp_task.pop_front();
         if (got_task.size() == 0) begin
            $display("case %0d: the engine emitted fewer tasks than expected", n);
            errs++;
         end else begin
            got = got_task.pop_front();
            if (got !== exp) begin
               $display("FAIL case %0d task_out got %h expected %h", n, got, exp);
               errs++;
            end
         end
      end
      if (got_task.size() != 0) begin
         $display("case %0d: the engine emitted %0d tasks too many", n, got_task.size());
         errs++;
      end
      while (exp_wcase.size() > 0 && exp_wcase[0] == n) begin
         void'(exp_wcase.pop_front());
         a = exp_waddr.pop_front();
         d = exp_wdata.pop_front();
         if (mem_model_inst.wr_addr_q.size() == 0) begin
            $display("case %0d: an expected memory write never came", n);
            errs++;
         end else begin
            if (mem_model_inst.wr_addr_q[0] !== a) begin
               $display("FAIL case %0d mem_req.aw_addr got %h expected %h", n,
                        mem_model_inst.wr_addr_q[0], a);
               errs++;
            end
            if (mem_model_inst.wr_data_q[0] !== d) begin
               $display("FAIL case %0d mem_req.w_data got %h expected %h", n,
                        mem_model_inst.wr_data_q[0], d);
               errs++;
            end
            void'(mem_model_inst.wr_addr_q.pop_front());
            void'(mem_model_inst.wr_data_q.pop_front());
         end
      end
      if (mem_model_inst.wr_addr_q.size() != 0) begin
         $display("case %0d: the engine wrote memory more often than expected", n);
         errs++;
      end
      // color and receive read scratch once, the first task also reads the header
      exp_reads = (case_task[n].ttype == color_pkg::COLOR_TASK ||
                   case_task[n].ttype == color_pkg::RECEIVE_TASK) ? 1 : 0;
      if (n == 0) exp_reads++;
      if (mem_model_inst.rd_count != exp_reads) begin
         $display("FAIL case %0d mem_req.ar_valid bursts got %h expected %h", n,
                  mem_model_inst.rd_count, exp_reads);
         errs++;
      end
      if (mem_model_inst.hdr_reads != 1) begin
         $display("FAIL case %0d mem_req.ar_addr reads at 0 got %h expected %h", n,
                  mem_model_inst.hdr_reads, 1);
         errs++;
      end
      if (n == 0 && mem_model_inst.hdr_len !== 8'(color_pkg::HEADER_WORDS - 1)) begin
         $display("FAIL case %0d mem_req.ar_len got %h expected %h", n,
                  mem_model_inst.hdr_len, 8'(color_pkg::HEADER_WORDS - 1));
         errs++;
      end
      if (errs == 0) begin
         $display("case %0d type %0d ok", n, case_task[n].ttype);
         passed++;
      end else begin
         $display("case %0d type %0d failed with %0d errors", n, case_task[n].ttype, errs);
         failed++;
      end
   endtask

   initial begin
      rstn           = 1'b0;
      start          = 1'b0;
      task_in        = '0;
      task_out_ready = 1'b1;
      stall_en       = 1'b0;
      out_s          = '0;
      out_v_s        = 1'b0;
      out_r_s        = 1'b0;
      n_cases        = 0;
      passed         = 0;
      failed         = 0;
      mem_model_inst.reset_state();
      read_cases();
      cycle_limit = CASE_CYCLES * (n_cases + 1);
      for (int i = 0; i < color_pkg::HEADER_WORDS; i++) begin
         mem_model_inst.poke(i * 4, hdr[i]);
      end
      repeat (10) @(negedge clk);
      rstn = 1'b1;
      // idle high, done and every valid low out of reset
      reset_levels = {idle, done, task_out_valid,
                      mem_req.ar_valid, mem_req.aw_valid, mem_req.w_valid};
      if (reset_levels !== 6'b10_0000) begin
         $display("FAIL reset {idle,done,task_out_valid,ar/aw/w_valid} got %h expected %h",
                  reset_levels, 6'b10_0000);
         failed++;
      end else begin
         $display("reset state ok");
         passed++;
      end
      if (n_cases == 0) begin
         $display("the case file holds no cases");
         failed++;
      end
      for (int n = 0; n < n_cases; n++) begin
         run_case(n);
      end
      $display("%0d tests run, %0d passed, %0d failed", n_cases + 1, passed, failed);
      if (failed == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== bench/l1_mem_model.sv ====
`timescale 1ns/100ps

module l1_mem_model #(
   parameter int WORDS = 1024
) (
   input  color_pkg::mem_req_t mem_req,
   output color_pkg::mem_rsp_t mem_rsp
);

   logic [color_pkg::WORD_W-1:0] mem [WORDS];
   logic [color_pkg::WORD_W-1:0] wr_addr_q [$];
   logic [color_pkg::WORD_W-1:0] wr_data_q [$];
   int unsigned                  rd_count;
   int unsigned                  hdr_reads;
   logic [7:0]                   hdr_len;

   color_pkg::mem_req_t          req_s; // request seen since the last falling edge
   color_pkg::mem_rsp_t          rsp_s;
   logic                         rd_busy;
   logic [color_pkg::WORD_W-1:0] rd_addr;
   logic [7:0]                   rd_left;
   logic                         w_pend;
   logic [color_pkg::WORD_W-1:0] w_addr;

   function automatic logic ready_draw(input logic stall);
      return stall ? ($urandom_range(3) != 0) : 1'b1;
   endfunction

   task automatic reset_state();
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = (i * 32'h9e3779b1) ^ 32'ha5a5_0000; // every address bit matters
      end
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_count  = 0;
      hdr_reads = 0;
      hdr_len   = '0;
      req_s     = '0;
      rsp_s     = '0;
      rd_busy   = 1'b0;
      rd_addr   = '0;
      rd_left   = '0;
      w_pend    = 1'b0;
      w_addr    = '0;
      mem_rsp   = '0;
   endtask

   task automatic poke(input logic [31:0] addr, input logic [31:0] data);
      mem[(addr >> 2) % WORDS] = data;
   endtask

   task automatic store(input logic [31:0] addr, input logic [31:0] data);
      mem[(addr >> 2) % WORDS] = data;
      wr_addr_q.push_back(addr);
      wr_data_q.push_back(data);
   endtask

   // called once per falling edge, settles the handshakes of the last rising edge
   task automatic tick(input logic stall);
      if (w_pend && req_s.w_valid && rsp_s.w_ready) begin
         store(w_addr, req_s.w_data);
         w_pend = 1'b0;
      end
      if (req_s.aw_valid && rsp_s.aw_ready) begin
         store(req_s.aw_addr, req_s.w_data); // first beat rides with the address
         w_pend = (req_s.aw_len != 0);
         w_addr = req_s.aw_addr + 4;
      end
      if (rd_busy && req_s.r_ready && rsp_s.r_valid) begin
         rd_busy = (rd_left != 0);
         rd_left = rd_left - 1'b1;
         rd_addr = rd_addr + 4;
      end
      if (req_s.ar_valid && rsp_s.ar_ready) begin
         rd_count++;
         if (req_s.ar_addr == 0) begin
            hdr_reads++;
            hdr_len = req_s.ar_len;
         end
         rd_busy = 1'b1;
         rd_addr = req_s.ar_addr;
         rd_left = req_s.ar_len;
      end
      req_s          = mem_req;
      rsp_s          = '0;
      rsp_s.ar_ready = !rd_busy && ready_draw(stall);
      rsp_s.aw_ready = !w_pend && ready_draw(stall);
      rsp_s.w_ready  = w_pend && ready_draw(stall);
      if (rd_busy && ready_draw(stall)) begin
         rsp_s.r_valid = 1'b1;
         rsp_s.r_data  = mem[(rd_addr >> 2) % WORDS];
         rsp_s.r_last  = (rd_left == 0);
      end
      mem_rsp = rsp_s;
   endtask

endmodule

// ==== build.f ====
rtl/color_pkg.sv
rtl/header_loader.sv
rtl/free_color.sv
rtl/enqueue_window.sv
rtl/vertex_task_fsm.sv
rtl/color_engine.sv
bench/l1_mem_model.sv
bench/color_engine_tb.sv

// ==== rtl/color_engine.sv ====
`timescale 1ns/100ps

module color_engine #(
   parameter int NUM_COLORS = 32
) (
   input  logic                clk,
   input  logic                rstn,
   input  logic                start,
   input  color_pkg::task_t    task_in,
   input  logic                task_out_ready,
   input  color_pkg::mem_rsp_t mem_rsp,
   output logic                done,
   output logic                idle,
   output color_pkg::task_t    task_out,
   output logic                task_out_valid,
   output color_pkg::mem_req_t mem_req
);

   color_pkg::mem_req_t          hdr_req, fsm_req;
   logic                         header_busy, header_valid;
   logic [color_pkg::WORD_W-1:0] num_v, color_base, scratch_base;
   logic [6:0]                   enq_limit;
   logic                         fetch, load, step, more;
   logic [color_pkg::WORD_W-1:0] win_end, offset;
   logic [NUM_COLORS-1:0]        bitmap;
   logic [5:0]                   color;

   assign mem_req = header_busy ? hdr_req : fsm_req; // loader owns port during burst

   header_loader header_loader_inst (
      .clk(clk), .rstn(rstn), .fetch(fetch), .mem_rsp(mem_rsp), .mem_req(hdr_req),
      .header_busy(header_busy), .header_valid(header_valid), .num_v(num_v),
      .color_base(color_base), .scratch_base(scratch_base), .enq_limit(enq_limit)
   );

   enqueue_window enqueue_window_inst (
      .clk(clk), .load(load), .step(step), .start_index(task_in.args),
      .last_index(num_v), .enq_limit(enq_limit), .win_end(win_end), .offset(offset),
      .more(more)
   );

   free_color #(.NUM_COLORS(NUM_COLORS)) free_color_inst (
      .bitmap(bitmap), .color(color)
   );

   vertex_task_fsm #(.NUM_COLORS(NUM_COLORS)) vertex_task_fsm_inst (
      .clk(clk), .rstn(rstn), .start(start), .task_in(task_in),
      .header_valid(header_valid), .num_v(num_v), .color_base(color_base),
      .scratch_base(scratch_base), .enq_limit(enq_limit), .win_end(win_end),
      .offset(offset), .more(more), .color(color), .task_out_ready(task_out_ready),
      .mem_rsp(mem_rsp), .fetch(fetch), .load(load), .step(step), .bitmap(bitmap),
      .done(done), .idle(idle), .task_out(task_out), .task_out_valid(task_out_valid),
      .mem_req(fsm_req)
   );

endmodule

// ==== rtl/color_pkg.sv ====
package color_pkg;

   localparam int WORD_W   = 32;
   localparam int TS_W     = 32;
   localparam int LOCALE_W = 32;
   localparam int TTYPE_W  = 4;
   localparam int ARGS_W   = 32;

   localparam logic [TTYPE_W-1:0] ENQUEUER_TASK = 4'd0;
   localparam logic [TTYPE_W-1:0] CALC_TASK     = 4'd1;
   localparam logic [TTYPE_W-1:0] COLOR_TASK    = 4'd2;
   localparam logic [TTYPE_W-1:0] RECEIVE_TASK  = 4'd3;

   // header layout, in words from address 0
   localparam int HEADER_WORDS      = 10;
   localparam int NUMV_WORD         = 1;
   localparam int COLOR_BASE_WORD   = 5;
   localparam int SCRATCH_BASE_WORD = 7;
   localparam int LIMIT_WORD        = 9;

   localparam int SCRATCH_SHIFT  = 3; // 8 bytes per vertex
   localparam int COUNTER_OFFSET = 0;
   localparam int BITMAP_OFFSET  = 4;
   localparam int COLOR_SHIFT    = 4; // 16 byte color slot

   typedef struct packed {
      logic [ARGS_W-1:0]   args;
      logic [TTYPE_W-1:0]  ttype;
      logic [LOCALE_W-1:0] locale;
      logic [TS_W-1:0]     ts;
   } task_t;

   typedef struct packed {
      logic              ar_valid;
      logic [WORD_W-1:0] ar_addr;
      logic [7:0]        ar_len; // beats minus one
      logic              aw_valid;
      logic [WORD_W-1:0] aw_addr;
      logic [7:0]        aw_len;
      logic              w_valid;
      logic [WORD_W-1:0] w_data;
      logic              w_last;
      logic              r_ready;
   } mem_req_t;

   typedef struct packed {
      logic              ar_ready;
      logic              r_valid;
      logic [WORD_W-1:0] r_data;
      logic              r_last;
      logic              aw_ready;
      logic              w_ready;
   } mem_rsp_t;

endpackage

// ==== rtl/enqueue_window.sv ====
`timescale 1ns/100ps

module enqueue_window (
   input  logic                         clk,
   input  logic                         load,
   input  logic                         step,
   input  logic [color_pkg::WORD_W-1:0] start_index,
   input  logic [color_pkg::WORD_W-1:0] last_index,
   input  logic [6:0]                   enq_limit,
   output logic [color_pkg::WORD_W-1:0] win_end,
   output logic [color_pkg::WORD_W-1:0] offset,
   output logic                         more
);

   logic [color_pkg::WORD_W:0] reach;

   // one spare bit so a large start cannot wrap
   assign reach = {1'b0, start_index} + (color_pkg::WORD_W + 1)'(enq_limit);

   always_ff @(posedge clk) begin
      if (load) begin
         offset <= start_index;
         if (reach > {1'b0, last_index}) begin
            win_end <= last_index; // clip at numV
         end else begin
            win_end <= reach[color_pkg::WORD_W-1:0];
         end
      end else if (step) begin
         offset <= offset + 1'b1;
      end
   end

   assign more = offset < win_end;

endmodule

// ==== rtl/free_color.sv ====
`timescale 1ns/100ps

module free_color #(
   parameter int NUM_COLORS = 32
) (
   input  logic [NUM_COLORS-1:0] bitmap,
   output logic [5:0]            color
);

   logic [5:0] low_zero;

   always_comb begin
      low_zero = '0;
      for (int i = NUM_COLORS - 1; i >= 0; i--) begin
         if (!bitmap[i]) begin
            low_zero = 6'(i); // last hit wins, so lowest index
         end
      end
   end

   always_comb begin
      if (bitmap == '0) begin
         color = '0;
      end else if (&bitmap) begin
         color = 6'(NUM_COLORS); // saturated
      end else begin
         color = low_zero;
      end
   end

endmodule

// ==== rtl/header_loader.sv ====
`timescale 1ns/100ps

module header_loader (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         fetch,
   input  color_pkg::mem_rsp_t          mem_rsp,
   output color_pkg::mem_req_t          mem_req,
   output logic                         header_busy,
   output logic                         header_valid,
   output logic [color_pkg::WORD_W-1:0] num_v,
   output logic [color_pkg::WORD_W-1:0] color_base,
   output logic [color_pkg::WORD_W-1:0] scratch_base,
   output logic [6:0]                   enq_limit
);

   logic       ar_pending;
   logic       reading;
   logic [3:0] beat;
   logic       beat_fire;

   assign beat_fire   = reading && mem_rsp.r_valid;
   assign header_busy = ar_pending || reading;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ar_pending   <= 1'b0;
         reading      <= 1'b0;
         header_valid <= 1'b0;
         beat         <= '0;
      end else begin
         if (fetch && !header_busy && !header_valid) begin
            ar_pending <= 1'b1; // one load per reset
         end else if (ar_pending && mem_rsp.ar_ready) begin
            ar_pending <= 1'b0;
            reading    <= 1'b1;
            beat       <= '0;
         end else if (beat_fire) begin
            beat <= beat + 1'b1;
            if (mem_rsp.r_last) begin
               reading      <= 1'b0;
               header_valid <= 1'b1;
            end
         end
      end
   end

   // base words hold word indices
   always_ff @(posedge clk) begin
      if (beat_fire) begin
         case (beat)
            4'(color_pkg::NUMV_WORD):         num_v <= mem_rsp.r_data;
            4'(color_pkg::COLOR_BASE_WORD):   color_base <= {mem_rsp.r_data[29:0], 2'b00};
            4'(color_pkg::SCRATCH_BASE_WORD): scratch_base <= {mem_rsp.r_data[29:0], 2'b00};
            4'(color_pkg::LIMIT_WORD):        enq_limit <= mem_rsp.r_data[6:0];
            default: ;
         endcase
      end
   end

   always_comb begin
      mem_req          = '0;
      mem_req.ar_valid = ar_pending;
      mem_req.ar_len   = 8'(color_pkg::HEADER_WORDS - 1);
      mem_req.r_ready  = reading;
   end

   a_ar_hold : assert property (@(posedge clk) disable iff (!rstn)
      mem_req.ar_valid && !mem_rsp.ar_ready |=> mem_req.ar_valid && $stable(mem_req.ar_addr));

endmodule

// ==== rtl/vertex_task_fsm.sv ====
`timescale 1ns/100ps

module vertex_task_fsm #(
   parameter int NUM_COLORS = 32
) (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         start,
   input  color_pkg::task_t             task_in,
   input  logic                         header_valid,
   input  logic [color_pkg::WORD_W-1:0] num_v,
   input  logic [color_pkg::WORD_W-1:0] color_base,
   input  logic [color_pkg::WORD_W-1:0] scratch_base,
   input  logic [6:0]                   enq_limit,
   input  logic [color_pkg::WORD_W-1:0] win_end,
   input  logic [color_pkg::WORD_W-1:0] offset,
   input  logic                         more,
   input  logic [5:0]                   color,
   input  logic                         task_out_ready,
   input  color_pkg::mem_rsp_t          mem_rsp,
   output logic                         fetch,
   output logic                         load,
   output logic                         step,
   output logic [NUM_COLORS-1:0]        bitmap,
   output logic                         done,
   output logic                         idle,
   output color_pkg::task_t             task_out,
   output logic                         task_out_valid,
   output color_pkg::mem_req_t          mem_req
);

   typedef enum logic [3:0] {
      IDLE, HDR_WAIT, DISPATCH,
      ENQ_CONT, ENQ_NODE,
      COLOR_READ, COLOR_WAIT, COLOR_WRITE,
      RECV_READ, RECV_WAIT, RECV_WR_CNT, RECV_WR_BMP, RECV_ENQ,
      FINISH
   } state_t;

   state_t                       state, state_next;
   color_pkg::task_t             cur_task;
   logic [color_pkg::WORD_W-1:0] counter;
   logic                         rd_beat; // second beat of scratch read
   logic [color_pkg::WORD_W-1:0] vtx_scratch;
   logic [color_pkg::WORD_W-1:0] vtx_color;
   logic [NUM_COLORS-1:0]        new_bitmap;
   logic                         bit_set;
   logic                         cnt_one;

   assign vtx_scratch = scratch_base + (cur_task.locale << color_pkg::SCRATCH_SHIFT);
   assign vtx_color   = color_base + (cur_task.locale << color_pkg::COLOR_SHIFT);
   assign new_bitmap  = bitmap | (NUM_COLORS'(1) << cur_task.args); // 0 mask when arg >= width
   assign bit_set     = (new_bitmap == bitmap);
   assign cnt_one     = (counter == 1);

   assign idle  = (state == IDLE);
   assign done  = (state == FINISH);
   assign fetch = idle && start && !header_valid;
   assign load  = (state == DISPATCH) && (cur_task.ttype == color_pkg::ENQUEUER_TASK);
   assign step  = (state == ENQ_NODE) && more && task_out_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state   <= IDLE;
         rd_beat <= 1'b0;
      end else begin
         state <= state_next;
         if (state == COLOR_READ || state == RECV_READ) begin
            rd_beat <= 1'b0;
         end else if (mem_req.r_ready && mem_rsp.r_valid) begin
            rd_beat <= !rd_beat;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (idle && start) begin
         cur_task <= task_in;
      end
      if (mem_req.r_ready && mem_rsp.r_valid) begin
         if (state == COLOR_WAIT || rd_beat) begin
            bitmap <= mem_rsp.r_data[NUM_COLORS-1:0];
         end else begin
            counter <= mem_rsp.r_data;
         end
      end
   end

   always_comb begin
      state_next     = state;
      mem_req        = '0;
      task_out       = '0;
      task_out_valid = 1'b0;
      case (state)
         IDLE: begin
            if (start) begin
               state_next = header_valid ? DISPATCH : HDR_WAIT;
            end
         end
         HDR_WAIT: begin
            if (header_valid) state_next = DISPATCH;
         end
         DISPATCH: begin
            case (cur_task.ttype)
               color_pkg::ENQUEUER_TASK: state_next = ENQ_CONT;
               color_pkg::COLOR_TASK:    state_next = COLOR_READ;
               color_pkg::RECEIVE_TASK:  state_next = RECV_READ;
               default:                  state_next = FINISH;
            endcase
         end
         ENQ_CONT: begin
            if (win_end < num_v) begin
               task_out.ttype  = color_pkg::ENQUEUER_TASK;
               task_out.locale = cur_task.args << 4; // spreads continuations
               task_out.args   = win_end;
               task_out_valid  = 1'b1;
               if (task_out_ready) state_next = ENQ_NODE;
            end else begin
               state_next = ENQ_NODE;
            end
         end
         ENQ_NODE: begin
            if (more) begin
               task_out.ttype  = color_pkg::CALC_TASK;
               task_out.locale = offset;
               task_out_valid  = 1'b1;
            end else begin
               state_next = FINISH;
            end
         end
         COLOR_READ: begin
            mem_req.ar_valid = 1'b1;
            mem_req.ar_addr  = vtx_scratch + color_pkg::BITMAP_OFFSET;
            if (mem_rsp.ar_ready) state_next = COLOR_WAIT;
         end
         COLOR_WAIT: begin
            mem_req.r_ready = 1'b1;
            if (mem_rsp.r_valid && mem_rsp.r_last) state_next = COLOR_WRITE;
         end
         COLOR_WRITE: begin
            mem_req.aw_valid = 1'b1;
            mem_req.aw_addr  = vtx_color;
            mem_req.w_valid  = 1'b1;
            mem_req.w_data   = color_pkg::WORD_W'(color);
            mem_req.w_last   = 1'b1;
            if (mem_rsp.aw_ready) state_next = FINISH;
         end
         RECV_READ: begin
            mem_req.ar_valid = 1'b1;
            mem_req.ar_addr  = vtx_scratch + color_pkg::COUNTER_OFFSET;
            mem_req.ar_len   = 8'd1; // counter then bitmap
            if (mem_rsp.ar_ready) state_next = RECV_WAIT;
         end
         RECV_WAIT: begin
            mem_req.r_ready = 1'b1;
            if (mem_rsp.r_valid && mem_rsp.r_last) state_next = RECV_WR_CNT;
         end
         RECV_WR_CNT: begin
            mem_req.aw_valid = 1'b1;
            mem_req.aw_addr  = vtx_scratch + color_pkg::COUNTER_OFFSET;
            mem_req.aw_len   = bit_set ? 8'd0 : 8'd1;
            mem_req.w_valid  = 1'b1;
            mem_req.w_data   = counter - 1'b1;
            mem_req.w_last   = bit_set;
            if (mem_rsp.aw_ready) begin
               if (!bit_set) state_next = RECV_WR_BMP;
               else state_next = cnt_one ? RECV_ENQ : FINISH;
            end
         end
         RECV_WR_BMP: begin
            mem_req.w_valid = 1'b1;
            mem_req.w_data  = color_pkg::WORD_W'(new_bitmap);
            mem_req.w_last  = 1'b1;
            if (mem_rsp.w_ready) state_next = cnt_one ? RECV_ENQ : FINISH;
         end
         RECV_ENQ: begin
            task_out.ttype  = color_pkg::COLOR_TASK;
            task_out.locale = cur_task.locale;
            task_out_valid  = 1'b1;
            if (task_out_ready) state_next = FINISH;
         end
         FINISH: state_next = IDLE;
         default: state_next = IDLE;
      endcase
   end

   a_out_stable : assert property (@(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=> task_out_valid && $stable(task_out));

   a_idle_quiet : assert property (@(posedge clk) disable iff (!rstn)
      idle |-> !(mem_req.ar_valid || mem_req.aw_valid || mem_req.w_valid));

endmodule
